// ==== sim.f ====
verilog/slot_pkg.sv
verilog/seq_ctrl_pkg.sv
verilog/slot_table.sv
verilog/slot_access.sv
verilog/task_stepper.sv
verilog/seq_control.sv
verilog/seq_core.sv
verification/tb_seq_core.sv

// ==== Bender.yml ====
package:
  name: seq_core

sources:
  - files:
      - verilog/slot_pkg.sv
      - verilog/seq_ctrl_pkg.sv
      - verilog/slot_table.sv
      - verilog/slot_access.sv
      - verilog/task_stepper.sv
      - verilog/seq_control.sv
      - verilog/seq_core.sv
  - target: simulation
    files:
      - verification/tb_seq_core.sv

// ==== verification/tb_seq_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_seq_core
    import slot_pkg::*, seq_ctrl_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // run limits
    //////////////////////////////////////////////////////////////////////
    localparam int test_len [5] = '{16, 3, 4, 2, 3};  // rough length of each test in steps
    localparam int watchdog_cycles = (test_len[0] + test_len[1] + test_len[2]
                                      + test_len[3] + test_len[4]) * 40;
    localparam int wait_limit = 200;  // cycles allowed for one state to be reached

    logic clk = 1'b0;
    logic reset;
    host_wr_t host_wr;
    logic host_wr_valid;
    logic host_wr_ok;
    slot_index_t rd_index;
    logic rd_req;
    slot_entry_t rd_entry;
    logic rd_ready;
    ctrl_cmd_t ctrl_cmd;
    logic ctrl_valid;
    slot_index_t end_cnt_in;
    logic end_cnt_valid;
    seq_state_t state;
    slot_index_t main_cnt;
    slot_index_t end_cnt;
    slot_entry_t slave_entry;
    logic reprog;
    logic reprog_accept = 1'b0;
    logic [init_task_cnt-1:0] init_task;
    logic [init_task_cnt-1:0] fin_init = '0;
    logic exec_start;
    logic exec_accept = 1'b0;
    logic fin_exec = 1'b0;

    integer seed = 50;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int errs_before;              // error count when the current test began
    int delay_left = 1;           // slave response countdown
    logic [profile_w-1:0] base_profile [slot_cnt];

    // reference model state
    seq_state_t m_state;
    slot_index_t m_cnt;
    slot_index_t m_end;
    logic [init_task_cnt-1:0] m_init;
    logic m_exec;
    slot_entry_t shadow [slot_cnt];

    seq_core i_seq_core (.*);

    always #4 clk = ~clk;  // 8 ns period

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic slot_entry_t random_entry();
        logic [159:0] r;
        r = {rand32(), rand32(), rand32(), rand32(), rand32()};
        return r[$bits(slot_entry_t)-1:0];
    endfunction

    task automatic report_mismatch(string sig, logic [149:0] got, logic [149:0] exp);
        err_cnt++;
        $display("mismatch %s: dut %h expected %h at %0t", sig, got, exp, $time);
    endtask

    task automatic step();
        @(posedge clk);
        #1;  // inputs change away from the edge
    endtask

    task automatic quiet_inputs();
        host_wr       = '0;
        host_wr_valid = 1'b0;
        rd_index      = '0;
        rd_req        = 1'b0;
        ctrl_cmd      = cmd_clear;
        ctrl_valid    = 1'b0;
        end_cnt_in    = '0;
        end_cnt_valid = 1'b0;
    endtask

    task automatic send_cmd(ctrl_cmd_t cmd);
        ctrl_cmd   = cmd;
        ctrl_valid = 1'b1;
        step();
        ctrl_valid = 1'b0;
    endtask

    task automatic set_end(slot_index_t last);
        end_cnt_in    = last;
        end_cnt_valid = 1'b1;
        step();
        end_cnt_valid = 1'b0;
    endtask

    task automatic host_write_and_read();
        slot_index_t idx;
        idx           = slot_index_t'(rand32());
        host_wr.index = idx;
        host_wr.entry = random_entry();
        host_wr.en    = slot_field_en_t'(rand32());  // random subset of fields
        host_wr_valid = 1'b1;
        step();
        host_wr_valid = 1'b0;
        rd_index      = idx;  // readback one cycle after the write
        rd_req        = 1'b1;
        step();
        rd_req        = 1'b0;
    endtask

    task automatic read_all();
        for (int i = 0; i < slot_cnt; i++) begin
            rd_index = slot_index_t'(i);
            rd_req   = 1'b1;
            step();
        end
        rd_req = 1'b0;
    endtask

    // host traffic that the core must ignore while it runs
    task automatic drive_traffic(int c);
        host_wr.index = slot_index_t'(rand32());
        host_wr.entry = random_entry();
        host_wr.en    = slot_field_en_t'(rand32());
        host_wr_valid = 1'b1;
        rd_index      = slot_index_t'(rand32());
        rd_req        = 1'b1;
        ctrl_cmd      = cmd_start;
        ctrl_valid    = (c % 5 == 2);   // restart attempt
        end_cnt_in    = slot_index_t'(3);
        end_cnt_valid = (c % 5 == 4);   // end count rewrite attempt
    endtask

    task automatic wait_state(seq_state_t target, bit traffic);
        int c;
        c = 0;
        while (state != target && c < wait_limit) begin
            if (traffic) drive_traffic(c);
            step();
            c++;
        end
        quiet_inputs();
        if (state != target) begin
            err_cnt++;
            $display("state %s not reached within %0d cycles", target.name(), wait_limit);
        end
    endtask

    task automatic end_test(string name);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
        errs_before = err_cnt;
    endtask

    //////////////////////////////////////////////////////////////////////
    // slave dma answers the open request after 1 to 4 cycles
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : slave_responder
        #1;
        reprog_accept = 1'b0;
        fin_init      = '0;
        exec_accept   = 1'b0;
        fin_exec      = 1'b0;
        if (!reset || !(reprog || (|init_task) || exec_start || state == st_wait_fin)) begin
            delay_left = 1 + ($unsigned(rand32()) % 4);  // nothing open so rearm
        end else if (delay_left > 1) begin
            delay_left = delay_left - 1;
            if (|init_task) begin
                fin_init = ~init_task & init_task_cnt'(rand32());  // stray finishes on idle lines
            end
        end else begin
            reprog_accept = reprog;
            fin_init      = init_task;              // finish only the active line
            exec_accept   = exec_start;
            fin_exec      = (state == st_wait_fin);
            delay_left    = 1 + ($unsigned(rand32()) % 4);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model of table and sequencer
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk or negedge reset) begin : reference_model
        if (!reset) begin
            m_state <= st_shutdown;
            m_cnt   <= '0;
            m_end   <= '0;
            m_init  <= '0;
            m_exec  <= 1'b0;
            for (int i = 0; i < slot_cnt; i++) shadow[i] <= '0;
        end else begin
            if (host_wr_valid && m_state == st_shutdown) begin  // host owns the table
                if (host_wr.en.src_addr) shadow[host_wr.index].src_addr <= host_wr.entry.src_addr;
                if (host_wr.en.src_size) shadow[host_wr.index].src_size <= host_wr.entry.src_size;
                if (host_wr.en.dst_addr) shadow[host_wr.index].dst_addr <= host_wr.entry.dst_addr;
                if (host_wr.en.dst_size) shadow[host_wr.index].dst_size <= host_wr.entry.dst_size;
                if (host_wr.en.status)   shadow[host_wr.index].status   <= host_wr.entry.status;
                if (host_wr.en.profile)  shadow[host_wr.index].profile  <= host_wr.entry.profile;
            end
            if (m_state == st_reprog && reprog_accept) begin
                shadow[m_cnt].profile <= shadow[m_cnt].profile + 1'b1;  // one bump per visit
            end
            if (end_cnt_valid && m_state == st_shutdown) m_end <= end_cnt_in;
            if (ctrl_valid && (ctrl_cmd == cmd_clear || ctrl_cmd == cmd_shutdown)) begin
                m_state <= st_shutdown;
                m_init  <= '0;   // both commands drop every task line
                m_exec  <= 1'b0;
                if (ctrl_cmd == cmd_clear) m_cnt <= '0;
            end else if (ctrl_valid && ctrl_cmd == cmd_start && m_state == st_shutdown) begin
                m_state <= st_reprog;
                m_cnt   <= '0;
            end else begin
                case (m_state)
                    st_reprog: if (reprog_accept) begin
                        m_state <= st_init;
                        m_init  <= 4'b0001;
                    end
                    st_init: if (|(fin_init & m_init)) begin
                        if (m_init[init_task_cnt-1]) begin
                            m_init  <= '0;
                            m_exec  <= 1'b1;
                            m_state <= st_trigger;
                        end else begin
                            m_init <= m_init << 1;  // next line
                        end
                    end
                    st_trigger: if (exec_accept && m_exec) begin
                        m_exec  <= 1'b0;
                        m_state <= st_wait_fin;
                    end
                    st_wait_fin: if (fin_exec) begin
                        if (m_cnt < m_end) begin
                            m_cnt   <= m_cnt + 1'b1;
                            m_state <= st_reprog;
                        end else begin
                            m_cnt   <= '0;
                            m_state <= st_shutdown;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks against the model
    //////////////////////////////////////////////////////////////////////
    a_state: assert property (@(posedge clk) disable iff (!reset) state == m_state)
        else report_mismatch("state", $sampled(state), $sampled(m_state));
    a_main_cnt: assert property (@(posedge clk) disable iff (!reset) main_cnt == m_cnt)
        else report_mismatch("main_cnt", $sampled(main_cnt), $sampled(m_cnt));
    a_end_cnt: assert property (@(posedge clk) disable iff (!reset) end_cnt == m_end)
        else report_mismatch("end_cnt", $sampled(end_cnt), $sampled(m_end));
    a_init_task: assert property (@(posedge clk) disable iff (!reset) init_task == m_init)
        else report_mismatch("init_task", $sampled(init_task), $sampled(m_init));
    a_exec_start: assert property (@(posedge clk) disable iff (!reset) exec_start == m_exec)
        else report_mismatch("exec_start", $sampled(exec_start), $sampled(m_exec));
    a_reprog: assert property (@(posedge clk) disable iff (!reset)
        reprog == (m_state == st_reprog))
        else report_mismatch("reprog", $sampled(reprog), $sampled(m_state == st_reprog));
    a_wr_ok: assert property (@(posedge clk) disable iff (!reset)
        host_wr_ok == (host_wr_valid && m_state == st_shutdown))
        else report_mismatch("host_wr_ok", $sampled(host_wr_ok), !$sampled(host_wr_ok));
    a_rd_ready: assert property (@(posedge clk) disable iff (!reset)
        rd_ready == (rd_req && m_state == st_shutdown))
        else report_mismatch("rd_ready", $sampled(rd_ready), !$sampled(rd_ready));
    a_rd_entry: assert property (@(posedge clk) disable iff (!reset)
        rd_ready |-> rd_entry == shadow[rd_index])
        else report_mismatch("rd_entry", $sampled(rd_entry), $sampled(shadow[rd_index]));
    a_slave_entry: assert property (@(posedge clk) disable iff (!reset)
        (m_state != st_shutdown) |-> slave_entry == shadow[m_cnt])
        else report_mismatch("slave_entry", $sampled(slave_entry), $sampled(shadow[m_cnt]));

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        reset = 1'b0;
        quiet_inputs();
        repeat (3) @(posedge clk);
        #1 reset = 1'b1;
        step();
        errs_before = err_cnt;

        for (int n = 0; n < 16; n++) host_write_and_read();
        read_all();
        end_test("host writes in shutdown");

        for (int i = 0; i < slot_cnt; i++) base_profile[i] = shadow[i].profile;
        set_end(slot_index_t'(2));
        send_cmd(cmd_start);
        wait_state(st_shutdown, 1'b0);
        end_test("full run to end count 2");

        for (int i = 0; i < slot_cnt; i++) begin
            rd_index = slot_index_t'(i);
            rd_req   = 1'b1;
            #1;  // combinational read settles
            a_profile: assert (rd_entry.profile == base_profile[i] + ((i <= 2) ? 1 : 0))
                else report_mismatch("profile", rd_entry.profile,
                                     profile_w'(base_profile[i] + ((i <= 2) ? 1 : 0)));
            step();
        end
        rd_req = 1'b0;
        end_test("profile bumped once per visited slot");

        set_end(slot_index_t'(1));
        send_cmd(cmd_start);
        wait_state(st_shutdown, 1'b1);  // writes, reads, start and end count while busy
        read_all();
        end_test("host locked out while running");

        set_end(slot_index_t'(3));
        send_cmd(cmd_start);
        wait_state(st_wait_fin, 1'b0);
        wait_state(st_init, 1'b0);      // second slot with its lines active
        send_cmd(cmd_shutdown);
        step();
        send_cmd(cmd_start);
        wait_state(st_trigger, 1'b0);
        send_cmd(cmd_clear);
        step();
        read_all();
        end_test("shutdown and clear mid run");

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/seq_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module seq_core
    import slot_pkg::*, seq_ctrl_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    // host table access
    input  wire host_wr_t            host_wr,
    input  wire                      host_wr_valid,
    output wire                      host_wr_ok,
    input  wire slot_index_t         rd_index,
    input  wire                      rd_req,
    output wire slot_entry_t         rd_entry,
    output wire                      rd_ready,
    // host control
    input  wire ctrl_cmd_t           ctrl_cmd,
    input  wire                      ctrl_valid,
    input  wire slot_index_t         end_cnt_in,
    input  wire                      end_cnt_valid,
    output wire seq_state_t          state,
    output wire slot_index_t         main_cnt,
    output wire slot_index_t         end_cnt,
    // slave dma
    output wire slot_entry_t         slave_entry,
    output wire                      reprog,
    input  wire                      reprog_accept,
    output wire [init_task_cnt-1:0]  init_task,
    input  wire [init_task_cnt-1:0]  fin_init,
    output wire                      exec_start,
    input  wire                      exec_accept,
    input  wire                      fin_exec
);

    logic           host_access;
    logic           profile_bump;
    logic           init_go;
    logic           abort;
    logic           init_done;
    logic           exec_launched;
    slot_index_t    table_wr_index;
    slot_index_t    table_rd_index;
    slot_entry_t    table_wr_entry;
    slot_field_en_t table_wr_en;
    slot_entry_t    table_rd_entry;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////
    seq_control i_seq_control (
        .clk           (clk),
        .reset         (reset),
        .ctrl_cmd      (ctrl_cmd),
        .ctrl_valid    (ctrl_valid),
        .end_cnt_in    (end_cnt_in),
        .end_cnt_valid (end_cnt_valid),
        .reprog_accept (reprog_accept),
        .init_done     (init_done),
        .exec_launched (exec_launched),
        .fin_exec      (fin_exec),
        .state         (state),
        .main_cnt      (main_cnt),
        .end_cnt       (end_cnt),
        .reprog        (reprog),
        .host_access   (host_access),
        .profile_bump  (profile_bump),
        .init_go       (init_go),
        .abort         (abort)
    );

    task_stepper i_task_stepper (
        .clk           (clk),
        .reset         (reset),
        .init_go       (init_go),
        .abort         (abort),
        .fin_init      (fin_init),
        .exec_accept   (exec_accept),
        .init_task     (init_task),
        .exec_start    (exec_start),
        .init_done     (init_done),
        .exec_launched (exec_launched)
    );

    //////////////////////////////////////////////////////////////////////
    // slot table datapath
    //////////////////////////////////////////////////////////////////////
    slot_access i_slot_access (
        .host_wr        (host_wr),
        .host_wr_valid  (host_wr_valid),
        .rd_index       (rd_index),
        .rd_req         (rd_req),
        .host_access    (host_access),
        .profile_bump   (profile_bump),
        .main_cnt       (main_cnt),
        .table_rd_entry (table_rd_entry),
        .host_wr_ok     (host_wr_ok),
        .rd_ready       (rd_ready),
        .table_wr_index (table_wr_index),
        .table_rd_index (table_rd_index),
        .table_wr_entry (table_wr_entry),
        .table_wr_en    (table_wr_en)
    );

    slot_table i_slot_table (
        .clk      (clk),
        .reset    (reset),
        .wr_index (table_wr_index),
        .wr_entry (table_wr_entry),
        .wr_en    (table_wr_en),
        .rd_index (table_rd_index),
        .rd_entry (table_rd_entry)
    );

    // one read port serves both, host while idle and slave while running
    assign rd_entry    = table_rd_entry;
    assign slave_entry = table_rd_entry;

endmodule

`default_nettype wire

// ==== verilog/seq_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module seq_control
    import slot_pkg::*, seq_ctrl_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    // host control
    input  wire ctrl_cmd_t   ctrl_cmd,
    input  wire              ctrl_valid,
    input  wire slot_index_t end_cnt_in,
    input  wire              end_cnt_valid,
    // progress from the slave and the stepper
    input  wire              reprog_accept,
    input  wire              init_done,
    input  wire              exec_launched,
    input  wire              fin_exec,
    // status
    output seq_state_t       state,
    output slot_index_t      main_cnt,
    output slot_index_t      end_cnt,
    // controls
    output logic             reprog,
    output logic             host_access,
    output logic             profile_bump,
    output logic             init_go,
    output logic             abort
);

    logic cmd_go;   // start that is honoured

    //////////////////////////////////////////////////////////////////////
    // command decode
    //////////////////////////////////////////////////////////////////////
    assign abort  = ctrl_valid & ((ctrl_cmd == cmd_clear) | (ctrl_cmd == cmd_shutdown));
    assign cmd_go = ctrl_valid & (ctrl_cmd == cmd_start) & (state == st_shutdown);

    // level and pulse controls
    assign reprog       = (state == st_reprog);
    assign host_access  = (state == st_shutdown);
    assign profile_bump = (state == st_reprog) & reprog_accept;  // once per visit
    assign init_go      = profile_bump;

    //////////////////////////////////////////////////////////////////////
    // end count, host writable only while idle
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            end_cnt <= '0;
        end else if (end_cnt_valid && (state == st_shutdown)) begin
            end_cnt <= end_cnt_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequencer fsm and slot counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= st_shutdown;
            main_cnt <= '0;
        end else if (abort) begin
            state <= st_shutdown;
            if (ctrl_cmd == cmd_clear) begin
                main_cnt <= '0;  // shutdown keeps the position
            end
        end else if (cmd_go) begin
            state    <= st_reprog;
            main_cnt <= '0;      // always begin at slot 0
        end else begin
            // ignored commands fall through, progress is not stalled
            case (state)
                st_shutdown: begin
                    state <= st_shutdown;
                end
                st_reprog: begin
                    if (reprog_accept) state <= st_init;
                end
                st_init: begin
                    if (init_done) state <= st_trigger;  // stepper saw last finish
                end
                st_trigger: begin
                    if (exec_launched) state <= st_wait_fin;
                end
                st_wait_fin: begin
                    if (fin_exec) begin
                        if (main_cnt < end_cnt) begin
                            main_cnt <= main_cnt + 1'b1;
                            state    <= st_reprog;   // next slot
                        end else begin
                            main_cnt <= '0;
                            state    <= st_shutdown; // table done
                        end
                    end
                end
                default: begin
                    state <= st_shutdown;  // unused codes recover to idle
                end
            endcase
        end
    end

    // end_cnt is frozen while running, so the counter stays inside the table run
    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!reset)
        (state != st_shutdown) |-> (main_cnt <= end_cnt)
    ) else $error("main_cnt %0d beyond end_cnt %0d", main_cnt, end_cnt);

endmodule

`default_nettype wire

// ==== verilog/task_stepper.sv ====
`timescale 1ns/1ns
`default_nettype none

module task_stepper
    import seq_ctrl_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     init_go,        // load first init line
    input  wire                     abort,          // clear or shutdown
    input  wire [init_task_cnt-1:0] fin_init,
    input  wire                     exec_accept,
    output logic [init_task_cnt-1:0] init_task,     // one hot toward the slave
    output logic                    exec_start,
    output logic                    init_done,      // last init line finished
    output logic                    exec_launched   // execute accepted
);

    logic init_hit;   // finish on the active line
    logic last_hit;   // finish on the final line

    assign init_hit = |(fin_init & init_task);  // finishes on idle lines are ignored
    assign last_hit = fin_init[init_task_cnt-1] & init_task[init_task_cnt-1];

    assign init_done     = last_hit;
    assign exec_launched = exec_start & exec_accept;

    //////////////////////////////////////////////////////////////////////
    // init line shifter and execute strobe
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            init_task  <= '0;
            exec_start <= 1'b0;
        end else if (abort) begin
            init_task  <= '0;     // drop every line at once
            exec_start <= 1'b0;
        end else begin
            if (init_go) begin
                init_task <= {{(init_task_cnt-1){1'b0}}, 1'b1};
            end else if (last_hit) begin
                init_task  <= '0;
                exec_start <= 1'b1;  // hand over to execute
            end else if (init_hit) begin
                init_task <= init_task << 1;
            end
            if (exec_launched) begin
                exec_start <= 1'b0;  // held until accepted
            end
        end
    end

    // at most one init line may be active toward the slave
    a_init_onehot: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0(init_task)
    ) else $error("init_task not one hot: %b", init_task);

endmodule

`default_nettype wire

// ==== verilog/slot_access.sv ====
`timescale 1ns/1ns
`default_nettype none

module slot_access
    import slot_pkg::*;
(
    // host side
    input  wire host_wr_t       host_wr,
    input  wire                 host_wr_valid,
    input  wire slot_index_t    rd_index,
    input  wire                 rd_req,
    // sequencer side
    input  wire                 host_access,     // high while idle
    input  wire                 profile_bump,    // one cycle, on reprog accept
    input  wire slot_index_t    main_cnt,
    input  wire slot_entry_t    table_rd_entry,
    // host status
    output logic                host_wr_ok,
    output logic                rd_ready,
    // table ports
    output slot_index_t         table_wr_index,
    output slot_index_t         table_rd_index,
    output slot_entry_t         table_wr_entry,
    output slot_field_en_t      table_wr_en
);

    //////////////////////////////////////////////////////////////////////
    // port steering
    //////////////////////////////////////////////////////////////////////
    assign table_wr_index = host_access ? host_wr.index : main_cnt;
    assign table_rd_index = host_access ? rd_index : main_cnt;  // slave sees main_cnt slot

    assign host_wr_ok = host_wr_valid & host_access;  // writes only while idle
    assign rd_ready   = rd_req & host_access;

    //////////////////////////////////////////////////////////////////////
    // write data and strobes
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        table_wr_entry = host_wr.entry;
        table_wr_en    = '0;
        if (host_wr_ok) begin
            table_wr_en = host_wr.en;  // only the fields the host selected
        end
        if (profile_bump) begin
            // read port already points at main_cnt, so this is read modify write
            table_wr_entry.profile = table_rd_entry.profile + 1'b1;
            table_wr_en            = '0;
            table_wr_en.profile    = 1'b1;
        end
    end

    // the bump comes from a running sequencer, the host only writes while idle
    a_bump_excl: assert final (!(profile_bump && host_access))
        else $error("profile bump while host owns the table");

endmodule

`default_nettype wire

// ==== verilog/slot_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module slot_table
    import slot_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire slot_index_t    wr_index,
    input  wire slot_entry_t    wr_entry,
    input  wire slot_field_en_t wr_en,
    input  wire slot_index_t    rd_index,
    output slot_entry_t    rd_entry
);

    slot_entry_t mem [slot_cnt];  // the slot records

    //////////////////////////////////////////////////////////////////////
    // write port, each field has its own strobe
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < slot_cnt; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_en.src_addr) mem[wr_index].src_addr <= wr_entry.src_addr;
            if (wr_en.src_size) mem[wr_index].src_size <= wr_entry.src_size;
            if (wr_en.dst_addr) mem[wr_index].dst_addr <= wr_entry.dst_addr;
            if (wr_en.dst_size) mem[wr_index].dst_size <= wr_entry.dst_size;
            if (wr_en.status)   mem[wr_index].status   <= wr_entry.status;
            if (wr_en.profile)  mem[wr_index].profile  <= wr_entry.profile;  // host or bump
        end
    end

    // read port, no latency
    assign rd_entry = mem[rd_index];

    // an x on a strobe would silently corrupt or skip a field
    a_wr_en_known: assert property (
        @(posedge clk) disable iff (!reset)
        !$isunknown(wr_en)
    ) else $error("slot_table write enable unknown");

endmodule

`default_nettype wire

// ==== verilog/seq_ctrl_pkg.sv ====
`default_nettype none

package seq_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // host command codes
    //////////////////////////////////////////////////////////////////////
    typedef logic [3:0] ctrl_cmd_t;

    localparam ctrl_cmd_t cmd_clear    = 4'd0;  // stop, zero the counter
    localparam ctrl_cmd_t cmd_shutdown = 4'd1;  // stop, counter kept
    localparam ctrl_cmd_t cmd_start    = 4'd2;  // only honoured when idle
    // every other code is ignored

    //////////////////////////////////////////////////////////////////////
    // sequencer state codes, visible to the host
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        st_shutdown = 4'd0,   // idle, host owns the table
        st_reprog   = 4'd1,   // waiting for reprogram accept
        st_init     = 4'd2,   // walking the init task lines
        st_trigger  = 4'd3,   // execute start raised
        st_wait_fin = 4'd4    // execution in progress
    } seq_state_t;

    // slave dma task geometry
    localparam int init_task_cnt = 4;  // src addr, src size, dst addr, dst size

endpackage

`default_nettype wire

// ==== verilog/slot_pkg.sv ====
`default_nettype none

package slot_pkg;

    //////////////////////////////////////////////////////////////////////
    // slot record geometry
    //////////////////////////////////////////////////////////////////////
    localparam int slot_index_w  = 2;                  // 2 bits, four slots
    localparam int slot_cnt      = 1 << slot_index_w;  // table depth
    localparam int src_addr_w    = 32;
    localparam int src_size_w    = 26;
    localparam int dst_addr_w    = 32;
    localparam int dst_size_w    = 26;
    localparam int slot_status_w = 2;
    localparam int profile_w     = 32;                 // visit counter

    typedef logic [slot_index_w-1:0] slot_index_t;

    // one table record, 150 bits
    typedef struct packed {
        logic [src_addr_w-1:0]    src_addr;
        logic [src_size_w-1:0]    src_size;
        logic [dst_addr_w-1:0]    dst_addr;
        logic [dst_size_w-1:0]    dst_size;
        logic [slot_status_w-1:0] status;
        logic [profile_w-1:0]     profile;
    } slot_entry_t;

    // per field write strobes, same field order as the record
    typedef struct packed {
        logic src_addr;
        logic src_size;
        logic dst_addr;
        logic dst_size;
        logic status;
        logic profile;
    } slot_field_en_t;

    // host write request
    typedef struct packed {
        slot_index_t    index;
        slot_entry_t    entry;
        slot_field_en_t en;
    } host_wr_t;

endpackage

`default_nettype wire
